// ==== list.f ====
dcachePkg.sv
dcacheFrames.sv
dcacheLookup.sv
dcacheControl.sv
dcache.sv
dcache_checker.sv
dcacheTb.sv

// ==== dcacheTb.sv ====
module dcacheTb
    import dcachePkg::*;
();

    localparam int HALF_PERIOD     = 20;
    localparam int QUARTER         = 10;  // sample point after the falling edge
    localparam int MEM_WORDS       = 256;
    localparam int TEST_COUNT      = 7;
    localparam int CYCLES_PER_TEST = 400;

    logic    CLK;
    logic    nRST;
    logic    halt;
    cpuReq_t cpuReq;
    cpuRsp_t cpuRsp;
    memReq_t memReq;
    memRsp_t memRsp;

    logic [WORD_W-1:0] mem [MEM_WORDS];     // memory model
    logic [WORD_W-1:0] refMem [MEM_WORDS];  // last value written per address
    int unsigned       stalls [MEM_WORDS];  // busy stretch per memory request
    int unsigned       stallPtr;
    logic              stretch;

    dcache DUT (
        .CLK    (CLK),
        .nRST   (nRST),
        .cpuReq (cpuReq),
        .halt   (halt),
        .cpuRsp (cpuRsp),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    always #HALF_PERIOD CLK = ~CLK;

    // initial memory contents, a function of the word index
    function automatic logic [WORD_W-1:0] fillWord(input int i);
        return {8'hD0 ^ 8'(i), 8'(i * 7), ~8'(i), 8'(i)};
    endfunction

    function automatic int memIdx(input logic [31:0] a);
        return int'(a[9:2]);  // byte address to word slot
    endfunction

    task automatic reportValue(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Result: FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "check failed");
    endtask

    // memory model, answers on the falling edge
    initial begin
        logic        active;
        int unsigned waitLeft;
        memRsp   = '0;
        active   = 1'b0;
        waitLeft = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        forever begin
            @(negedge CLK);
            if (memReq.ren || memReq.wen) begin
                if (!active) begin
                    active   = 1'b1;  // new request
                    waitLeft = stretch ? stalls[stallPtr % MEM_WORDS] : 0;
                    stallPtr++;
                end
                if (waitLeft != 0) begin
                    memRsp.busy = 1'b1;
                    waitLeft--;
                end else begin
                    memRsp.busy = 1'b0;  // completes on the next rising edge
                    if (memReq.wen) begin
                        mem[memIdx(memReq.addr)] = memReq.storeData;
                    end else begin
                        memRsp.loadData = mem[memIdx(memReq.addr)];
                    end
                    active = 1'b0;
                end
            end else begin
                memRsp.busy = 1'b0;
                active      = 1'b0;
            end
        end
    end

    // hold one request until the cache answers with hit
    task automatic access(input logic isWrite, input logic [31:0] addr,
                          input logic [WORD_W-1:0] data, output logic [WORD_W-1:0] loadData);
        @(negedge CLK);
        cpuReq.read      = !isWrite;
        cpuReq.write     = isWrite;
        cpuReq.addr      = addr;
        cpuReq.storeData = data;
        #(QUARTER);
        while (!cpuRsp.hit) begin
            @(negedge CLK);
            #(QUARTER);
        end
        loadData = cpuRsp.loadData;
        if (isWrite) begin
            refMem[memIdx(addr)] = data;
        end
        @(negedge CLK);
        cpuReq = '0;
    endtask

    task automatic store(input logic [31:0] addr, input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] unused;
        access(1'b1, addr, data, unused);
    endtask

    task automatic readCheck(input logic [31:0] addr);
        logic [WORD_W-1:0] got;
        access(1'b0, addr, '0, got);
        assert (got == refMem[memIdx(addr)])
            else reportValue("cpuRsp.loadData", got, refMem[memIdx(addr)]);
    endtask

    task automatic memCheck(input logic [31:0] addr);
        assert (mem[memIdx(addr)] == refMem[memIdx(addr)])
            else reportValue($sformatf("mem[0x%h]", addr), mem[memIdx(addr)],
                             refMem[memIdx(addr)]);
    endtask

    // cold block, both words
    task automatic readMissFill(input logic [31:0] base);
        readCheck(base + 32'h08);
        readCheck(base + 32'h0C);
    endtask

    task automatic writeThenRead(input logic [31:0] base);
        logic [WORD_W-1:0] d;
        d = $urandom;
        store(base + 32'h10, d);  // miss, fill, then store
        readCheck(base + 32'h10);
        store(base + 32'h14, $urandom);
        readCheck(base + 32'h14);
        store(base + 32'h10, ~d);  // resident word
        readCheck(base + 32'h10);
    endtask

    // three tags in set 3, third store evicts the first
    task automatic evictWriteBack(input logic [31:0] base);
        logic [31:0] a0;
        a0 = base + 32'h18;
        for (int k = 0; k < 3; k++) begin
            store(a0 + k * 32'h40, $urandom);
        end
        memCheck(a0);
        memCheck(a0 + 32'h4);
        for (int k = 0; k < 3; k++) begin
            readCheck(a0 + k * 32'h40);
        end
    endtask

    task automatic haltFlush(input logic [31:0] base);
        int sets [4] = '{0, 4, 5, 7};
        foreach (sets[n]) begin
            store(base + sets[n] * 8, $urandom);
            store(base + 32'h40 + sets[n] * 8 + 4, $urandom);
        end
        @(negedge CLK);
        halt        = 1'b1;
        cpuReq.read = 1'b1;
        cpuReq.addr = base;  // resident, must still not hit
        #(QUARTER);
        while (!cpuRsp.flushed) begin
            assert (!cpuRsp.hit) else reportFailure("cache answered a request during halt");
            @(negedge CLK);
            #(QUARTER);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            memCheck(32'(i * 4));
        end
        @(negedge CLK);
        cpuReq = '0;
    endtask

    // watchdog
    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge CLK);
        $display("simulation timed out waiting for the cache");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        CLK      = 1'b0;
        nRST     = 1'b0;
        halt     = 1'b0;
        cpuReq   = '0;
        stretch  = 1'b0;
        stallPtr = 0;
        void'($urandom(35869));
        for (int i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = fillWord(i);
            stalls[i] = $urandom % 4;
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        readMissFill(32'h000);
        writeThenRead(32'h000);
        evictWriteBack(32'h000);

        stretch = 1'b1;  // memory now stalls 0 to 3 cycles
        readMissFill(32'h200);
        writeThenRead(32'h200);
        evictWriteBack(32'h200);

        haltFlush(32'h300);

        if (DUT.chk.violations == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d port assertions failed", DUT.chk.violations);
            $display("Result: FAILED");
            $fatal(1, "checker violations");
        end
    end

endmodule

// ==== dcache_checker.sv ====
module dcache_checker
    import dcachePkg::*;
(
    input logic    CLK,
    input logic    nRST,
    input logic    halt,
    input cpuRsp_t cpuRsp,
    input memReq_t memReq,
    input memRsp_t memRsp
);

    int unsigned violations;  // read by the testbench at the end

    initial violations = 0;

    // one direction per request
    assert property (@(posedge CLK) disable iff (!nRST) !(memReq.ren && memReq.wen))
        else begin
            $error("memory read and write requested together");
            violations++;
        end

    // stalled request must not move
    assert property (@(posedge CLK) disable iff (!nRST)
        (memReq.ren || memReq.wen) && memRsp.busy |=> memReq == $past(memReq))
        else begin
            $error("memory request changed while busy was high");
            violations++;
        end

    assert property (@(posedge CLK) disable iff (!nRST) cpuRsp.flushed |=> cpuRsp.flushed)
        else begin
            $error("flushed dropped before reset");
            violations++;
        end

    assert property (@(posedge CLK) disable iff (!nRST) halt |-> !cpuRsp.hit)
        else begin
            $error("hit raised while halt is high");
            violations++;
        end

endmodule

bind dcache dcache_checker chk (.*);

// ==== dcache.sv ====
module dcache
    import dcachePkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  cpuReq_t  cpuReq,
    input  logic     halt,
    output cpuRsp_t  cpuRsp,
    output memReq_t  memReq,
    input  memRsp_t  memRsp
);

    frame_t [NUM_WAYS-1:0] setFrames;
    frame_t                flushFrame;
    frame_t                victimFrame;
    frameWr_t              wr;
    logic [4:0]            flushSlot;
    logic [NUM_SETS-1:0]   lru;
    logic [WORD_W-1:0]     word;
    logic                  hit;
    logic                  hitWay;
    logic                  victimWay;
    logic                  lruEn;
    logic                  lruWay;
    logic                  clearAll;

    dcacheFrames frames (
        .CLK        (CLK),
        .nRST       (nRST),
        .rdIdx      (cpuReq.addr.idx),
        .setFrames  (setFrames),
        .flushSlot  (flushSlot),
        .flushFrame (flushFrame),
        .wr         (wr),
        .lruEn      (lruEn),
        .lruIdx     (cpuReq.addr.idx),  // hits only touch the requested set
        .lruWay     (lruWay),
        .lru        (lru),
        .clearAll   (clearAll)
    );

    dcacheLookup lookup (
        .req         (cpuReq),
        .setFrames   (setFrames),
        .lruBit      (lru[cpuReq.addr.idx]),
        .hit         (hit),
        .hitWay      (hitWay),
        .victimWay   (victimWay),
        .victimFrame (victimFrame),
        .word        (word)
    );

    dcacheControl control (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (cpuReq),
        .halt        (halt),
        .hit         (hit),
        .hitWay      (hitWay),
        .victimWay   (victimWay),
        .victimFrame (victimFrame),
        .word        (word),
        .flushFrame  (flushFrame),
        .flushSlot   (flushSlot),
        .rsp         (cpuRsp),
        .memReq      (memReq),
        .memRsp      (memRsp),
        .wr          (wr),
        .lruEn       (lruEn),
        .lruWay      (lruWay),
        .clearAll    (clearAll)
    );

endmodule

// ==== dcacheControl.sv ====
module dcacheControl
    import dcachePkg::*;
(
    input  logic               CLK,
    input  logic               nRST,
    input  cpuReq_t            req,
    input  logic               halt,
    input  logic               hit,
    input  logic               hitWay,
    input  logic               victimWay,
    input  frame_t             victimFrame,
    input  logic [WORD_W-1:0]  word,
    input  frame_t             flushFrame,
    output logic [4:0]         flushSlot,
    output cpuRsp_t            rsp,
    output memReq_t            memReq,
    input  memRsp_t            memRsp,
    output frameWr_t           wr,
    output logic               lruEn,
    output logic               lruWay,
    output logic               clearAll
);

    ctlState_t state, nextState;

    logic reqValid;
    logic slotDirty;
    logic slotDone;
    logic wordSel;  // block offset of the word in flight

    assign reqValid  = req.read || req.write;
    assign slotDirty = flushFrame.valid && flushFrame.dirty;
    assign slotDone  = !slotDirty || !memRsp.busy;  // clean slots take one cycle
    assign wordSel   = (state == writeBack1) || (state == fill1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= idle;
            flushSlot <= '0;
        end else begin
            state <= nextState;
            if (state == flushing && slotDone) begin
                flushSlot <= flushSlot + 5'd1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (halt) begin
                    nextState = flushing;  // halt wins over a pending request
                end else if (reqValid && !hit) begin
                    if (victimFrame.valid && victimFrame.dirty) begin
                        nextState = writeBack0;
                    end else begin
                        nextState = fill0;
                    end
                end
            end
            writeBack0: begin
                if (!memRsp.busy) begin
                    nextState = writeBack1;
                end
            end
            writeBack1: begin
                if (!memRsp.busy) begin
                    nextState = fill0;
                end
            end
            fill0: begin
                if (!memRsp.busy) begin
                    nextState = fill1;
                end
            end
            fill1: begin
                if (!memRsp.busy) begin
                    nextState = idle;  // request hits next cycle
                end
            end
            flushing: begin
                if (slotDone && flushSlot == 5'(FLUSH_STEPS - 1)) begin
                    nextState = flushed;
                end
            end
            flushed: nextState = flushed;  // only reset leaves
            default: nextState = idle;
        endcase
    end

    always_comb begin
        rsp.hit      = 1'b0;
        rsp.loadData = word;
        rsp.flushed  = (state == flushed);
        memReq       = '0;
        wr           = '0;
        wr.idx       = req.addr.idx;
        wr.way       = victimWay;
        wr.tag       = req.addr.tag;
        lruEn        = 1'b0;
        lruWay       = hitWay;
        clearAll     = (state == flushed);

        case (state)
            idle: begin
                if (!halt && reqValid && hit) begin
                    rsp.hit = 1'b1;
                    lruEn   = 1'b1;
                    if (req.write) begin
                        wr.en                       = 1'b1;
                        wr.way                      = hitWay;
                        wr.wordEn[req.addr.blkOff]  = 1'b1;
                        wr.data[req.addr.blkOff]    = req.storeData;
                        wr.setDirty                 = 1'b1;
                    end
                end
            end
            writeBack0, writeBack1: begin
                // victim block goes back under its own tag
                memReq.wen       = 1'b1;
                memReq.addr      = '{tag: victimFrame.tag, idx: req.addr.idx,
                                     blkOff: wordSel, bytOff: 2'b00};
                memReq.storeData = victimFrame.data[wordSel];
            end
            fill0, fill1: begin
                memReq.ren            = 1'b1;
                memReq.addr           = '{tag: req.addr.tag, idx: req.addr.idx,
                                          blkOff: wordSel, bytOff: 2'b00};
                wr.en                 = !memRsp.busy;
                wr.wordEn[wordSel]    = 1'b1;
                wr.data[wordSel]      = memRsp.loadData;
                if (state == fill0) begin
                    wr.clrValid = 1'b1;  // block is half old, half new
                    wr.clrDirty = 1'b1;
                end else begin
                    wr.setValid = 1'b1;
                    wr.setDirty = req.write;
                end
            end
            flushing: begin
                if (slotDirty) begin
                    memReq.wen       = 1'b1;
                    memReq.addr      = '{tag: flushFrame.tag, idx: flushSlot[3:1],
                                         blkOff: flushSlot[0], bytOff: 2'b00};
                    memReq.storeData = flushFrame.data[flushSlot[0]];
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== dcacheLookup.sv ====
module dcacheLookup
    import dcachePkg::*;
(
    input  cpuReq_t                req,
    input  frame_t [NUM_WAYS-1:0]  setFrames,
    input  logic                   lruBit,
    output logic                   hit,
    output logic                   hitWay,
    output logic                   victimWay,
    output frame_t                 victimFrame,
    output logic [WORD_W-1:0]      word
);

    logic [NUM_WAYS-1:0] match;
    logic [NUM_WAYS-1:0] free;

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = setFrames[w].valid && (setFrames[w].tag == req.addr.tag);
            free[w]  = !setFrames[w].valid;
        end
    end

    assign hit    = |match;
    assign hitWay = match[1];  // way 0 otherwise

    // an empty way is filled before anything gets evicted
    always_comb begin
        if (free[0]) begin
            victimWay = 1'b0;
        end else if (free[1]) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lruBit;
        end
    end

    assign victimFrame = setFrames[victimWay];

    // word at the block offset of the matching way
    assign word = setFrames[hitWay].data[req.addr.blkOff];

endmodule

// ==== dcacheFrames.sv ====
module dcacheFrames
    import dcachePkg::*;
(
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [IDX_W-1:0]            rdIdx,
    output frame_t [NUM_WAYS-1:0]       setFrames,
    input  logic [4:0]                  flushSlot,
    output frame_t                      flushFrame,
    input  frameWr_t                    wr,
    input  logic                        lruEn,
    input  logic [IDX_W-1:0]            lruIdx,
    input  logic                        lruWay,
    output logic [NUM_SETS-1:0]         lru,
    input  logic                        clearAll
);

    // state bits per set and way
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty;

    // payload
    logic [TAG_W-1:0]                 tags [NUM_SETS][NUM_WAYS];
    logic [BLK_WORDS-1:0][WORD_W-1:0] data [NUM_SETS][NUM_WAYS];

    function automatic frame_t frameAt(input logic [IDX_W-1:0] s, input logic w);
        frame_t f;
        f.valid = valid[s][w];
        f.dirty = dirty[s][w];
        f.tag   = tags[s][w];
        f.data  = data[s][w];
        return f;
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else if (clearAll) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (wr.en) begin
                if (wr.setValid) begin
                    valid[wr.idx][wr.way] <= 1'b1;
                end else if (wr.clrValid) begin
                    valid[wr.idx][wr.way] <= 1'b0;
                end
                if (wr.setDirty) begin
                    dirty[wr.idx][wr.way] <= 1'b1;
                end else if (wr.clrDirty) begin
                    dirty[wr.idx][wr.way] <= 1'b0;
                end
            end
            if (lruEn) begin
                lru[lruIdx] <= ~lruWay;  // other way becomes the victim
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (clearAll) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    tags[s][w] <= '0;
                    data[s][w] <= '0;
                end
            end
        end else if (wr.en) begin
            if (wr.setValid) begin
                tags[wr.idx][wr.way] <= wr.tag;
            end
            for (int i = 0; i < BLK_WORDS; i++) begin
                if (wr.wordEn[i]) begin
                    data[wr.idx][wr.way][i] <= wr.data[i];
                end
            end
        end
    end

    // combinational read ports
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            setFrames[w] = frameAt(rdIdx, 1'(w));
        end
        flushFrame = frameAt(flushSlot[3:1], flushSlot[4]);  // bit 4 picks the way
    end

endmodule

// ==== dcachePkg.sv ====
package dcachePkg;

    localparam int WORD_W      = 32;
    localparam int IDX_W       = 3;
    localparam int NUM_SETS    = 1 << IDX_W;
    localparam int NUM_WAYS    = 2;
    localparam int BLK_WORDS   = 2;
    localparam int TAG_W       = 32 - IDX_W - 1 - 2;  // minus block and byte offset
    localparam int FLUSH_STEPS = NUM_SETS * NUM_WAYS * BLK_WORDS;

    // word address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkOff;
        logic [1:0]       bytOff;
    } dAddr_t;

    typedef struct packed {
        logic                             valid;
        logic                             dirty;
        logic [TAG_W-1:0]                 tag;
        logic [BLK_WORDS-1:0][WORD_W-1:0] data;
    } frame_t;

    typedef struct packed {
        logic              read;
        logic              write;
        dAddr_t            addr;
        logic [WORD_W-1:0] storeData;
    } cpuReq_t;

    typedef struct packed {
        logic              hit;
        logic [WORD_W-1:0] loadData;
        logic              flushed;
    } cpuRsp_t;

    typedef struct packed {
        logic              ren;
        logic              wen;
        dAddr_t            addr;
        logic [WORD_W-1:0] storeData;
    } memReq_t;

    typedef struct packed {
        logic              busy;      // request held while high
        logic [WORD_W-1:0] loadData;
    } memRsp_t;

    // partial update of one way of one set
    typedef struct packed {
        logic                             en;
        logic [IDX_W-1:0]                 idx;
        logic                             way;
        logic [BLK_WORDS-1:0]             wordEn;
        logic [BLK_WORDS-1:0][WORD_W-1:0] data;
        logic                             setValid;  // also loads the tag
        logic                             clrValid;
        logic                             setDirty;
        logic                             clrDirty;
        logic [TAG_W-1:0]                 tag;
    } frameWr_t;

    typedef enum logic [2:0] {
        idle,
        writeBack0,
        writeBack1,
        fill0,
        fill1,
        flushing,
        flushed
    } ctlState_t;

endpackage
